// File: logic/video_mode_pkg.sv
package video_mode_pkg;

	////////////////////
	// Switch codes
	////////////////////
	typedef enum logic [3:0] {
		MODE_VGA      = 4'b0000,  // 640x480
		MODE_SVGA     = 4'b0001,  // 800x600
		MODE_HDTV720P = 4'b0010,  // 1280x720, also the fallback
		MODE_XGA      = 4'b0011,  // 1024x768
		MODE_SXGA     = 4'b1000,  // 1280x1024
		MODE_CAMERA   = 4'b1001   // 1280x720 camera raster
	} video_mode_e;

	// Widths
	localparam int SW_W  = 4;   // Mode switches
	localparam int CNT_W = 11;  // Raster counters and thresholds
	localparam int MD_W  = 8;   // Synthesizer M and D

	// Switch filter, short enough for simulation
	localparam int DEBOUNCE_CYCLES = 16;
	localparam int DB_CNT_W = $clog2(DEBOUNCE_CYCLES);
	localparam logic [DB_CNT_W-1:0] DB_CNT_MAX = DB_CNT_W'(DEBOUNCE_CYCLES - 1);

	localparam int GO_DELAY = 16;  // Load event to programming strobe

	////////////////////
	// Raster constants
	////////////////////

	// 640x480@60
	localparam logic [CNT_W-1:0] HPIXELS_VGA = 11'd640;
	localparam logic [CNT_W-1:0] VLINES_VGA  = 11'd480;
	localparam logic [CNT_W-1:0] HSYNCPW_VGA = 11'd96;
	localparam logic [CNT_W-1:0] VSYNCPW_VGA = 11'd2;
	localparam logic [CNT_W-1:0] HFNPRCH_VGA = 11'd16;
	localparam logic [CNT_W-1:0] VFNPRCH_VGA = 11'd11;
	localparam logic [CNT_W-1:0] HBKPRCH_VGA = 11'd48;
	localparam logic [CNT_W-1:0] VBKPRCH_VGA = 11'd31;

	// 800x600@60
	localparam logic [CNT_W-1:0] HPIXELS_SVGA = 11'd800;
	localparam logic [CNT_W-1:0] VLINES_SVGA  = 11'd600;
	localparam logic [CNT_W-1:0] HSYNCPW_SVGA = 11'd128;
	localparam logic [CNT_W-1:0] VSYNCPW_SVGA = 11'd4;
	localparam logic [CNT_W-1:0] HFNPRCH_SVGA = 11'd40;
	localparam logic [CNT_W-1:0] VFNPRCH_SVGA = 11'd1;
	localparam logic [CNT_W-1:0] HBKPRCH_SVGA = 11'd88;
	localparam logic [CNT_W-1:0] VBKPRCH_SVGA = 11'd23;

	// 1024x768@60
	localparam logic [CNT_W-1:0] HPIXELS_XGA = 11'd1024;
	localparam logic [CNT_W-1:0] VLINES_XGA  = 11'd768;
	localparam logic [CNT_W-1:0] HSYNCPW_XGA = 11'd136;
	localparam logic [CNT_W-1:0] VSYNCPW_XGA = 11'd6;
	localparam logic [CNT_W-1:0] HFNPRCH_XGA = 11'd24;
	localparam logic [CNT_W-1:0] VFNPRCH_XGA = 11'd3;
	localparam logic [CNT_W-1:0] HBKPRCH_XGA = 11'd160;
	localparam logic [CNT_W-1:0] VBKPRCH_XGA = 11'd29;

	// 1280x1024@60
	localparam logic [CNT_W-1:0] HPIXELS_SXGA = 11'd1280;
	localparam logic [CNT_W-1:0] VLINES_SXGA  = 11'd1024;
	localparam logic [CNT_W-1:0] HSYNCPW_SXGA = 11'd112;
	localparam logic [CNT_W-1:0] VSYNCPW_SXGA = 11'd3;
	localparam logic [CNT_W-1:0] HFNPRCH_SXGA = 11'd48;
	localparam logic [CNT_W-1:0] VFNPRCH_SXGA = 11'd1;
	localparam logic [CNT_W-1:0] HBKPRCH_SXGA = 11'd248;
	localparam logic [CNT_W-1:0] VBKPRCH_SXGA = 11'd38;

	// 1280x720@60
	localparam logic [CNT_W-1:0] HPIXELS_HDTV720P = 11'd1280;
	localparam logic [CNT_W-1:0] VLINES_HDTV720P  = 11'd720;
	localparam logic [CNT_W-1:0] HSYNCPW_HDTV720P = 11'd40;
	localparam logic [CNT_W-1:0] VSYNCPW_HDTV720P = 11'd5;
	localparam logic [CNT_W-1:0] HFNPRCH_HDTV720P = 11'd110;
	localparam logic [CNT_W-1:0] VFNPRCH_HDTV720P = 11'd5;
	localparam logic [CNT_W-1:0] HBKPRCH_HDTV720P = 11'd220;
	localparam logic [CNT_W-1:0] VBKPRCH_HDTV720P = 11'd20;

	// Camera, 720p with trimmed sync and porches
	localparam logic [CNT_W-1:0] HPIXELS_CAMERA = 11'd1280;
	localparam logic [CNT_W-1:0] VLINES_CAMERA  = 11'd720;
	localparam logic [CNT_W-1:0] HSYNCPW_CAMERA = 11'd39;
	localparam logic [CNT_W-1:0] VSYNCPW_CAMERA = 11'd4;
	localparam logic [CNT_W-1:0] HFNPRCH_CAMERA = 11'd110;
	localparam logic [CNT_W-1:0] VFNPRCH_CAMERA = 11'd4;
	localparam logic [CNT_W-1:0] HBKPRCH_CAMERA = 11'd220;
	localparam logic [CNT_W-1:0] VBKPRCH_CAMERA = 11'd22;

	////////////////////
	// Pixel clock ratios, true M/D from 50 MHz
	////////////////////
	localparam logic [MD_W-1:0] PCLK_M_VGA      = 8'd2;    // 25 MHz
	localparam logic [MD_W-1:0] PCLK_D_VGA      = 8'd4;
	localparam logic [MD_W-1:0] PCLK_M_SVGA     = 8'd4;    // 40 MHz
	localparam logic [MD_W-1:0] PCLK_D_SVGA     = 8'd5;
	localparam logic [MD_W-1:0] PCLK_M_XGA      = 8'd13;   // 65 MHz
	localparam logic [MD_W-1:0] PCLK_D_XGA      = 8'd10;
	localparam logic [MD_W-1:0] PCLK_M_SXGA     = 8'd54;   // 108 MHz
	localparam logic [MD_W-1:0] PCLK_D_SXGA     = 8'd25;
	localparam logic [MD_W-1:0] PCLK_M_CAMERA   = 8'd135;
	localparam logic [MD_W-1:0] PCLK_D_CAMERA   = 8'd91;
	localparam logic [MD_W-1:0] PCLK_M_HDTV720P = 8'd248;  // ~74.25 MHz
	localparam logic [MD_W-1:0] PCLK_D_HDTV720P = 8'd167;

endpackage

// File: logic/mode_switch_filter.sv
module mode_switch_filter (
	input  logic                              clk50m_bufg,
	input  logic                              RSTBTN,
	input  logic [video_mode_pkg::SW_W-1:0]   sw,
	output video_mode_pkg::video_mode_e       mode,
	output logic                              mode_change
);

	logic [video_mode_pkg::SW_W-1:0]     sw_s1;      // First sync stage
	logic [video_mode_pkg::SW_W-1:0]     sw_s2;      // Second sync stage
	logic [video_mode_pkg::SW_W-1:0]     sw_q;       // Compare register
	logic [video_mode_pkg::DB_CNT_W-1:0] stable_cnt [video_mode_pkg::SW_W];
	logic [video_mode_pkg::SW_W-1:0]     accept;     // Bit held long enough
	logic [video_mode_pkg::SW_W-1:0]     code_next;  // Debounced code

	////////////////////
	// Synchronizer
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_s1 <= '0;
			sw_s2 <= '0;
			sw_q  <= '0;
		end else begin
			sw_s1 <= sw;
			sw_s2 <= sw_s1;
			sw_q  <= sw_s2;  // Extra stage, three cycles in all
		end
	end

	////////////////////
	// Per-bit debounce
	////////////////////

	// Counts while a bit disagrees with the held mode, saturates at max
	always_ff @(posedge clk50m_bufg) begin
		for (int i = 0; i < video_mode_pkg::SW_W; i++) begin
			if (RSTBTN || (sw_q[i] == mode[i]))
				stable_cnt[i] <= '0;  // Agreement or bounce back
			else if (stable_cnt[i] != video_mode_pkg::DB_CNT_MAX)
				stable_cnt[i] <= stable_cnt[i] + 1'b1;
		end
	end

	always_comb begin
		for (int i = 0; i < video_mode_pkg::SW_W; i++) begin
			accept[i] = (sw_q[i] != mode[i]) && (stable_cnt[i] == video_mode_pkg::DB_CNT_MAX);
			code_next[i] = accept[i] ? sw_q[i] : mode[i];
		end
	end

	// Held mode doubles as the accepted code
	// A bit accepted right behind a change waits one cycle, counter stays saturated
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			mode        <= video_mode_pkg::MODE_VGA;
			mode_change <= 1'b0;
		end else if (!mode_change && (code_next != mode)) begin
			mode        <= video_mode_pkg::video_mode_e'(code_next);  // Unknown codes kept raw
			mode_change <= 1'b1;
		end else begin
			mode_change <= 1'b0;
		end
	end

endmodule

// File: logic/pixel_clock_setup.sv
module pixel_clock_setup (
	input  logic                            clk50m_bufg,
	input  logic                            RSTBTN,
	input  video_mode_pkg::video_mode_e     mode,
	input  logic                            mode_change,
	output logic [video_mode_pkg::MD_W-1:0] pclk_m,
	output logic [video_mode_pkg::MD_W-1:0] pclk_d,
	output logic                            prog_go
);

	logic                                pwrup;   // First cycle out of reset
	logic                                load;    // Load event
	logic [video_mode_pkg::GO_DELAY-1:0] go_sr;   // Strobe delay line

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN)
			pwrup <= 1'b1;
		else
			pwrup <= 1'b0;
	end

	assign load = pwrup | mode_change;

	////////////////////
	// M and D lookup, offset by one for the synthesizer
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (load) begin
			case (mode)
				video_mode_pkg::MODE_VGA: begin
					pclk_m <= video_mode_pkg::PCLK_M_VGA - 1'b1;
					pclk_d <= video_mode_pkg::PCLK_D_VGA - 1'b1;
				end
				video_mode_pkg::MODE_SVGA: begin
					pclk_m <= video_mode_pkg::PCLK_M_SVGA - 1'b1;
					pclk_d <= video_mode_pkg::PCLK_D_SVGA - 1'b1;
				end
				video_mode_pkg::MODE_XGA: begin
					pclk_m <= video_mode_pkg::PCLK_M_XGA - 1'b1;
					pclk_d <= video_mode_pkg::PCLK_D_XGA - 1'b1;
				end
				video_mode_pkg::MODE_SXGA: begin
					pclk_m <= video_mode_pkg::PCLK_M_SXGA - 1'b1;
					pclk_d <= video_mode_pkg::PCLK_D_SXGA - 1'b1;
				end
				video_mode_pkg::MODE_CAMERA: begin
					pclk_m <= video_mode_pkg::PCLK_M_CAMERA - 1'b1;
					pclk_d <= video_mode_pkg::PCLK_D_CAMERA - 1'b1;
				end
				default: begin  // 720p and any unknown code
					pclk_m <= video_mode_pkg::PCLK_M_HDTV720P - 1'b1;
					pclk_d <= video_mode_pkg::PCLK_D_HDTV720P - 1'b1;
				end
			endcase
		end
	end

	// Go strobe trails the load by GO_DELAY cycles
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN)
			go_sr <= '0;
		else
			go_sr <= {go_sr[video_mode_pkg::GO_DELAY-2:0], load};
	end

	assign prog_go = go_sr[video_mode_pkg::GO_DELAY-1];

	// Load events never come back to back, so neither does go
	a_go_single : assert property (
		@(posedge clk50m_bufg) disable iff (RSTBTN)
		prog_go |=> !prog_go
	);

endmodule

// File: logic/mode_timing_table.sv
module mode_timing_table (
	input  video_mode_pkg::video_mode_e      mode,
	output logic [video_mode_pkg::CNT_W-1:0] tc_hsblnk,
	output logic [video_mode_pkg::CNT_W-1:0] tc_hssync,
	output logic [video_mode_pkg::CNT_W-1:0] tc_hesync,
	output logic [video_mode_pkg::CNT_W-1:0] tc_heblnk,
	output logic [video_mode_pkg::CNT_W-1:0] tc_vsblnk,
	output logic [video_mode_pkg::CNT_W-1:0] tc_vssync,
	output logic [video_mode_pkg::CNT_W-1:0] tc_vesync,
	output logic [video_mode_pkg::CNT_W-1:0] tc_veblnk,
	output logic                             sync_negative
);

	// Raw raster figures of the selected mode
	logic [video_mode_pkg::CNT_W-1:0] h_act;
	logic [video_mode_pkg::CNT_W-1:0] h_fp;
	logic [video_mode_pkg::CNT_W-1:0] h_sw;
	logic [video_mode_pkg::CNT_W-1:0] h_bp;
	logic [video_mode_pkg::CNT_W-1:0] v_act;
	logic [video_mode_pkg::CNT_W-1:0] v_fp;
	logic [video_mode_pkg::CNT_W-1:0] v_sw;
	logic [video_mode_pkg::CNT_W-1:0] v_bp;

	////////////////////
	// Mode select
	////////////////////
	always_comb begin
		sync_negative = 1'b0;  // Positive unless VGA or XGA
		case (mode)
			video_mode_pkg::MODE_VGA: begin
				sync_negative = 1'b1;
				h_act = video_mode_pkg::HPIXELS_VGA;  h_fp = video_mode_pkg::HFNPRCH_VGA;
				h_sw  = video_mode_pkg::HSYNCPW_VGA;  h_bp = video_mode_pkg::HBKPRCH_VGA;
				v_act = video_mode_pkg::VLINES_VGA;   v_fp = video_mode_pkg::VFNPRCH_VGA;
				v_sw  = video_mode_pkg::VSYNCPW_VGA;  v_bp = video_mode_pkg::VBKPRCH_VGA;
			end
			video_mode_pkg::MODE_SVGA: begin
				h_act = video_mode_pkg::HPIXELS_SVGA;  h_fp = video_mode_pkg::HFNPRCH_SVGA;
				h_sw  = video_mode_pkg::HSYNCPW_SVGA;  h_bp = video_mode_pkg::HBKPRCH_SVGA;
				v_act = video_mode_pkg::VLINES_SVGA;   v_fp = video_mode_pkg::VFNPRCH_SVGA;
				v_sw  = video_mode_pkg::VSYNCPW_SVGA;  v_bp = video_mode_pkg::VBKPRCH_SVGA;
			end
			video_mode_pkg::MODE_XGA: begin
				sync_negative = 1'b1;
				h_act = video_mode_pkg::HPIXELS_XGA;  h_fp = video_mode_pkg::HFNPRCH_XGA;
				h_sw  = video_mode_pkg::HSYNCPW_XGA;  h_bp = video_mode_pkg::HBKPRCH_XGA;
				v_act = video_mode_pkg::VLINES_XGA;   v_fp = video_mode_pkg::VFNPRCH_XGA;
				v_sw  = video_mode_pkg::VSYNCPW_XGA;  v_bp = video_mode_pkg::VBKPRCH_XGA;
			end
			video_mode_pkg::MODE_SXGA: begin
				h_act = video_mode_pkg::HPIXELS_SXGA;  h_fp = video_mode_pkg::HFNPRCH_SXGA;
				h_sw  = video_mode_pkg::HSYNCPW_SXGA;  h_bp = video_mode_pkg::HBKPRCH_SXGA;
				v_act = video_mode_pkg::VLINES_SXGA;   v_fp = video_mode_pkg::VFNPRCH_SXGA;
				v_sw  = video_mode_pkg::VSYNCPW_SXGA;  v_bp = video_mode_pkg::VBKPRCH_SXGA;
			end
			video_mode_pkg::MODE_CAMERA: begin
				h_act = video_mode_pkg::HPIXELS_CAMERA;  h_fp = video_mode_pkg::HFNPRCH_CAMERA;
				h_sw  = video_mode_pkg::HSYNCPW_CAMERA;  h_bp = video_mode_pkg::HBKPRCH_CAMERA;
				v_act = video_mode_pkg::VLINES_CAMERA;   v_fp = video_mode_pkg::VFNPRCH_CAMERA;
				v_sw  = video_mode_pkg::VSYNCPW_CAMERA;  v_bp = video_mode_pkg::VBKPRCH_CAMERA;
			end
			default: begin  // 720p, also catches unlisted codes
				h_act = video_mode_pkg::HPIXELS_HDTV720P;  h_fp = video_mode_pkg::HFNPRCH_HDTV720P;
				h_sw  = video_mode_pkg::HSYNCPW_HDTV720P;  h_bp = video_mode_pkg::HBKPRCH_HDTV720P;
				v_act = video_mode_pkg::VLINES_HDTV720P;   v_fp = video_mode_pkg::VFNPRCH_HDTV720P;
				v_sw  = video_mode_pkg::VSYNCPW_HDTV720P;  v_bp = video_mode_pkg::VBKPRCH_HDTV720P;
			end
		endcase
	end

	////////////////////
	// Cumulative thresholds
	////////////////////
	assign tc_hsblnk = h_act - 1'b1;          // Last active pixel
	assign tc_hssync = tc_hsblnk + h_fp;      // End of front porch
	assign tc_hesync = tc_hssync + h_sw;      // Last sync pixel
	assign tc_heblnk = tc_hesync + h_bp;      // Last pixel of the line
	assign tc_vsblnk = v_act - 1'b1;
	assign tc_vssync = tc_vsblnk + v_fp;
	assign tc_vesync = tc_vssync + v_sw;
	assign tc_veblnk = tc_vesync + v_bp;      // Last line of the frame

endmodule

// File: logic/raster_timing.sv
module raster_timing (
	input  logic                             clk50m_bufg,
	input  logic                             RSTBTN,
	input  logic                             mode_change,
	input  logic [video_mode_pkg::CNT_W-1:0] tc_hsblnk,
	input  logic [video_mode_pkg::CNT_W-1:0] tc_hssync,
	input  logic [video_mode_pkg::CNT_W-1:0] tc_hesync,
	input  logic [video_mode_pkg::CNT_W-1:0] tc_heblnk,
	input  logic [video_mode_pkg::CNT_W-1:0] tc_vsblnk,
	input  logic [video_mode_pkg::CNT_W-1:0] tc_vssync,
	input  logic [video_mode_pkg::CNT_W-1:0] tc_vesync,
	input  logic [video_mode_pkg::CNT_W-1:0] tc_veblnk,
	input  logic                             sync_negative,
	output logic [video_mode_pkg::CNT_W-1:0] hcount,
	output logic [video_mode_pkg::CNT_W-1:0] vcount,
	output logic                             hsync,
	output logic                             vsync,
	output logic                             de
);

	logic line_end;    // Last pixel of a line
	logic frame_end;   // Last line of a frame
	logic hblank;
	logic vblank;
	logic hsync_raw;
	logic vsync_raw;
	logic hsync_q;     // First output stage
	logic vsync_q;
	logic de_q;

	////////////////////
	// Counters
	////////////////////
	assign line_end  = (hcount == tc_heblnk);
	assign frame_end = (vcount == tc_veblnk);

	// Restart on reset and on the cycle after a mode change
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || mode_change) begin
			hcount <= '0;
			vcount <= '0;
		end else if (line_end) begin
			hcount <= '0;
			if (frame_end)
				vcount <= '0;
			else
				vcount <= vcount + 1'b1;  // Next line
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	////////////////////
	// Blank and sync decode
	////////////////////
	assign hblank    = (hcount > tc_hsblnk);
	assign vblank    = (vcount > tc_vsblnk);
	assign hsync_raw = (hcount > tc_hssync) && (hcount <= tc_hesync);
	assign vsync_raw = (vcount > tc_vssync) && (vcount <= tc_vesync);

	////////////////////
	// Two-stage output pipe
	////////////////////

	// Idle sync level after reset is the VGA one, high
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
			de_q    <= 1'b0;
			hsync   <= 1'b1;
			vsync   <= 1'b1;
			de      <= 1'b0;
		end else begin
			hsync_q <= hsync_raw ^ sync_negative;  // Polarity flip
			vsync_q <= vsync_raw ^ sync_negative;
			de_q    <= !hblank && !vblank;
			hsync   <= hsync_q;
			vsync   <= vsync_q;
			de      <= de_q;
		end
	end

	// Table switches with the mode, counter catches up one cycle later
	a_hcount_range : assert property (
		@(posedge clk50m_bufg) disable iff (RSTBTN)
		!mode_change |-> (hcount <= tc_heblnk)
	);

endmodule

// File: logic/video_mode_top.sv
module video_mode_top (
	input  logic                             clk50m_bufg,
	input  logic                             RSTBTN,
	input  logic [video_mode_pkg::SW_W-1:0]  sw,
	output video_mode_pkg::video_mode_e      mode,
	output logic [video_mode_pkg::MD_W-1:0]  pclk_m,
	output logic [video_mode_pkg::MD_W-1:0]  pclk_d,
	output logic                             prog_go,
	output logic [video_mode_pkg::CNT_W-1:0] hcount,
	output logic [video_mode_pkg::CNT_W-1:0] vcount,
	output logic                             hsync,
	output logic                             vsync,
	output logic                             de
);

	logic mode_change;  // One-cycle strobe from the filter

	// Thresholds from the table
	logic [video_mode_pkg::CNT_W-1:0] tc_hsblnk;
	logic [video_mode_pkg::CNT_W-1:0] tc_hssync;
	logic [video_mode_pkg::CNT_W-1:0] tc_hesync;
	logic [video_mode_pkg::CNT_W-1:0] tc_heblnk;
	logic [video_mode_pkg::CNT_W-1:0] tc_vsblnk;
	logic [video_mode_pkg::CNT_W-1:0] tc_vssync;
	logic [video_mode_pkg::CNT_W-1:0] tc_vesync;
	logic [video_mode_pkg::CNT_W-1:0] tc_veblnk;
	logic                             sync_negative;

	////////////////////
	// Mode and clock
	////////////////////
	mode_switch_filter u_filter (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.mode        (mode),
		.mode_change (mode_change)
	);

	pixel_clock_setup u_clock (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.mode        (mode),
		.mode_change (mode_change),
		.pclk_m      (pclk_m),
		.pclk_d      (pclk_d),
		.prog_go     (prog_go)
	);

	////////////////////
	// Raster
	////////////////////
	mode_timing_table u_table (
		.mode          (mode),
		.tc_hsblnk     (tc_hsblnk),
		.tc_hssync     (tc_hssync),
		.tc_hesync     (tc_hesync),
		.tc_heblnk     (tc_heblnk),
		.tc_vsblnk     (tc_vsblnk),
		.tc_vssync     (tc_vssync),
		.tc_vesync     (tc_vesync),
		.tc_veblnk     (tc_veblnk),
		.sync_negative (sync_negative)
	);

	raster_timing u_raster (
		.clk50m_bufg   (clk50m_bufg),
		.RSTBTN        (RSTBTN),
		.mode_change   (mode_change),
		.tc_hsblnk     (tc_hsblnk),
		.tc_hssync     (tc_hssync),
		.tc_hesync     (tc_hesync),
		.tc_heblnk     (tc_heblnk),
		.tc_vsblnk     (tc_vsblnk),
		.tc_vssync     (tc_vssync),
		.tc_vesync     (tc_vesync),
		.tc_veblnk     (tc_veblnk),
		.sync_negative (sync_negative),
		.hcount        (hcount),
		.vcount        (vcount),
		.hsync         (hsync),
		.vsync         (vsync),
		.de            (de)
	);

endmodule

// File: tests/tb_video_checks.sv
module tb_video_checks (
	input logic                             clk50m_bufg,
	input logic                             RSTBTN,
	input logic [video_mode_pkg::SW_W-1:0]  sw,
	input logic [video_mode_pkg::SW_W-1:0]  mode,
	input logic                             mode_change,
	input logic [video_mode_pkg::MD_W-1:0]  pclk_m,
	input logic [video_mode_pkg::MD_W-1:0]  pclk_d,
	input logic                             prog_go,
	input logic [video_mode_pkg::CNT_W-1:0] hcount,
	input logic [video_mode_pkg::CNT_W-1:0] vcount,
	input logic                             hsync,
	input logic                             vsync,
	input logic                             de
);
	timeunit 1ns;
	timeprecision 1ps;

	// Sync chain plus debounce, less the edge that restarts the hold count
	localparam int SETTLE_HOLD = 3 + video_mode_pkg::DEBOUNCE_CYCLES - 1;
	localparam int GO = video_mode_pkg::GO_DELAY;

	int errors = 0;

	logic [5:0]  hold;       // Cycles sw has stayed put
	logic [3:0]  sw_q;
	logic [3:0]  mode_q;
	logic        rst_q;
	logic        chg;        // Mode moved on the last edge
	logic        load_ev;    // Clock setup load, as seen from outside
	logic [GO-1:0] load_hist;
	logic [15:0] pclk_exp;   // {M-1, D-1}
	logic [2:0]  since;      // Cycles since the last load
	logic        quiet;      // Raster settled in the current mode
	logic [10:0] hp, hfp, hsw, hbp;
	logic [10:0] vl, vfp, vsw, vbp;
	logic [10:0] h_tot;
	logic [10:0] v_tot;
	logic [10:0] h_next;
	logic [10:0] v_next;
	logic [10:0] h_next_q;
	logic [10:0] v_next_q;
	logic        neg;
	logic        hs_exp;
	logic        vs_exp;
	logic        de_exp;
	logic [2:0]  out_q1;     // {hsync, vsync, de} one edge on
	logic [2:0]  out_q2;

	// Returns {hpix, hfp, hsw, hbp, vlines, vfp, vsw, vbp}
	function automatic logic [87:0] mode_figures(input logic [3:0] m);
		case (m)
			video_mode_pkg::MODE_VGA:
				return {video_mode_pkg::HPIXELS_VGA, video_mode_pkg::HFNPRCH_VGA,
					video_mode_pkg::HSYNCPW_VGA, video_mode_pkg::HBKPRCH_VGA,
					video_mode_pkg::VLINES_VGA, video_mode_pkg::VFNPRCH_VGA,
					video_mode_pkg::VSYNCPW_VGA, video_mode_pkg::VBKPRCH_VGA};
			video_mode_pkg::MODE_SVGA:
				return {video_mode_pkg::HPIXELS_SVGA, video_mode_pkg::HFNPRCH_SVGA,
					video_mode_pkg::HSYNCPW_SVGA, video_mode_pkg::HBKPRCH_SVGA,
					video_mode_pkg::VLINES_SVGA, video_mode_pkg::VFNPRCH_SVGA,
					video_mode_pkg::VSYNCPW_SVGA, video_mode_pkg::VBKPRCH_SVGA};
			video_mode_pkg::MODE_XGA:
				return {video_mode_pkg::HPIXELS_XGA, video_mode_pkg::HFNPRCH_XGA,
					video_mode_pkg::HSYNCPW_XGA, video_mode_pkg::HBKPRCH_XGA,
					video_mode_pkg::VLINES_XGA, video_mode_pkg::VFNPRCH_XGA,
					video_mode_pkg::VSYNCPW_XGA, video_mode_pkg::VBKPRCH_XGA};
			video_mode_pkg::MODE_SXGA:
				return {video_mode_pkg::HPIXELS_SXGA, video_mode_pkg::HFNPRCH_SXGA,
					video_mode_pkg::HSYNCPW_SXGA, video_mode_pkg::HBKPRCH_SXGA,
					video_mode_pkg::VLINES_SXGA, video_mode_pkg::VFNPRCH_SXGA,
					video_mode_pkg::VSYNCPW_SXGA, video_mode_pkg::VBKPRCH_SXGA};
			video_mode_pkg::MODE_CAMERA:
				return {video_mode_pkg::HPIXELS_CAMERA, video_mode_pkg::HFNPRCH_CAMERA,
					video_mode_pkg::HSYNCPW_CAMERA, video_mode_pkg::HBKPRCH_CAMERA,
					video_mode_pkg::VLINES_CAMERA, video_mode_pkg::VFNPRCH_CAMERA,
					video_mode_pkg::VSYNCPW_CAMERA, video_mode_pkg::VBKPRCH_CAMERA};
			default:  // 720p and any unlisted code
				return {video_mode_pkg::HPIXELS_HDTV720P, video_mode_pkg::HFNPRCH_HDTV720P,
					video_mode_pkg::HSYNCPW_HDTV720P, video_mode_pkg::HBKPRCH_HDTV720P,
					video_mode_pkg::VLINES_HDTV720P, video_mode_pkg::VFNPRCH_HDTV720P,
					video_mode_pkg::VSYNCPW_HDTV720P, video_mode_pkg::VBKPRCH_HDTV720P};
		endcase
	endfunction

	// Synthesizer wants both ratio terms less one
	function automatic logic [15:0] clock_ratio(input logic [3:0] m);
		logic [15:0] ratio;
		case (m)
			video_mode_pkg::MODE_VGA:    ratio = {video_mode_pkg::PCLK_M_VGA, video_mode_pkg::PCLK_D_VGA};
			video_mode_pkg::MODE_SVGA:   ratio = {video_mode_pkg::PCLK_M_SVGA, video_mode_pkg::PCLK_D_SVGA};
			video_mode_pkg::MODE_XGA:    ratio = {video_mode_pkg::PCLK_M_XGA, video_mode_pkg::PCLK_D_XGA};
			video_mode_pkg::MODE_SXGA:   ratio = {video_mode_pkg::PCLK_M_SXGA, video_mode_pkg::PCLK_D_SXGA};
			video_mode_pkg::MODE_CAMERA: ratio = {video_mode_pkg::PCLK_M_CAMERA,
				video_mode_pkg::PCLK_D_CAMERA};
			default:                     ratio = {video_mode_pkg::PCLK_M_HDTV720P,
				video_mode_pkg::PCLK_D_HDTV720P};
		endcase
		return {ratio[15:8] - 8'd1, ratio[7:0] - 8'd1};
	endfunction

	////////////////////
	// Reference model
	////////////////////
	assign chg     = (mode != mode_q);
	assign load_ev = !RSTBTN && (rst_q || chg);  // Power-up or new mode
	assign quiet   = (since >= 3) && !load_ev;
	assign {hp, hfp, hsw, hbp, vl, vfp, vsw, vbp} = mode_figures(mode);
	assign h_tot   = hp + hfp + hsw + hbp;
	assign v_tot   = vl + vfp + vsw + vbp;
	assign neg     = (mode == video_mode_pkg::MODE_VGA) || (mode == video_mode_pkg::MODE_XGA);
	assign h_next  = (hcount == h_tot - 1'b1) ? '0 : hcount + 1'b1;
	assign v_next  = (hcount != h_tot - 1'b1) ? vcount :
		(vcount == v_tot - 1'b1) ? '0 : vcount + 1'b1;
	assign hs_exp  = (hcount >= hp + hfp) && (hcount < hp + hfp + hsw);  // Sync follows front porch
	assign vs_exp  = (vcount >= vl + vfp) && (vcount < vl + vfp + vsw);
	assign de_exp  = (hcount < hp) && (vcount < vl);

	always_ff @(posedge clk50m_bufg) begin
		rst_q    <= RSTBTN;
		mode_q   <= mode;
		sw_q     <= sw;
		h_next_q <= h_next;
		v_next_q <= v_next;
		out_q1   <= {hs_exp ^ neg, vs_exp ^ neg, de_exp};
		out_q2   <= out_q1;  // Same two-stage lag as the outputs
		if (load_ev)
			pclk_exp <= clock_ratio(mode);
		if (RSTBTN) begin
			hold      <= '0;
			since     <= '0;
			load_hist <= '0;
		end else begin
			load_hist <= {load_hist[GO-2:0], load_ev};
			if (sw != sw_q)
				hold <= '0;           // Switches moved
			else if (hold != '1)
				hold <= hold + 1'b1;
			if (load_ev)
				since <= '0;
			else if (since != '1)
				since <= since + 1'b1;
		end
	end

	////////////////////
	// Checks
	////////////////////
	a_reset_idle : assert property (@(posedge clk50m_bufg)
		$fell(RSTBTN) |-> !prog_go && !de && hsync && vsync)
		else begin
			errors = errors + 1;
			$display("%0t: outputs not at their idle levels right after reset", $time);
		end

	a_mode_settle : assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		hold == SETTLE_HOLD |-> mode == sw)
		else begin
			errors = errors + 1;
			$display("MISMATCH %0t mode expected %b actual %b", $time, $sampled(sw),
				$sampled(mode));
		end

	// Bounces shorter than the debounce window never reach this point
	a_mode_when : assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		chg |-> hold == SETTLE_HOLD)
		else begin
			errors = errors + 1;
			$display("%0t: mode changed while the switches had not settled", $time);
		end

	a_strobe : assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		mode_change == chg)
		else begin
			errors = errors + 1;
			$display("MISMATCH %0t mode_change expected %b actual %b", $time, $sampled(chg),
				$sampled(mode_change));
		end

	a_go : assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		prog_go == load_hist[GO-1])
		else begin
			errors = errors + 1;
			$display("MISMATCH %0t prog_go expected %b actual %b", $time,
				$sampled(load_hist[GO-1]), $sampled(prog_go));
		end

	a_pclk : assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		load_ev |=> {pclk_m, pclk_d} == pclk_exp)
		else begin
			errors = errors + 1;
			$display("MISMATCH %0t pclk_m/pclk_d expected %0d/%0d actual %0d/%0d", $time,
				$sampled(pclk_exp[15:8]), $sampled(pclk_exp[7:0]), $sampled(pclk_m),
				$sampled(pclk_d));
		end

	a_restart : assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		chg |=> hcount == '0 && vcount == '0)
		else begin
			errors = errors + 1;
			$display("MISMATCH %0t hcount/vcount expected 0/0 actual %0d/%0d", $time,
				$sampled(hcount), $sampled(vcount));
		end

	a_counters : assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		quiet |=> {hcount, vcount} == {h_next_q, v_next_q})
		else begin
			errors = errors + 1;
			$display("MISMATCH %0t hcount/vcount expected %0d/%0d actual %0d/%0d", $time,
				$sampled(h_next_q), $sampled(v_next_q), $sampled(hcount), $sampled(vcount));
		end

	a_outputs : assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		quiet |-> {hsync, vsync, de} == out_q2)
		else begin
			errors = errors + 1;
			$display("MISMATCH %0t hsync/vsync/de expected %b actual %b", $time,
				$sampled(out_q2), $sampled({hsync, vsync, de}));
		end

endmodule

// File: tests/tb_video_mode.sv
module tb_video_mode;
	timeunit 1ns;
	timeprecision 1ps;

	// VGA raster size, the longest stretch of the run
	localparam int H_VGA = video_mode_pkg::HPIXELS_VGA + video_mode_pkg::HFNPRCH_VGA
		+ video_mode_pkg::HSYNCPW_VGA + video_mode_pkg::HBKPRCH_VGA;
	localparam int V_VGA = video_mode_pkg::VLINES_VGA + video_mode_pkg::VFNPRCH_VGA
		+ video_mode_pkg::VSYNCPW_VGA + video_mode_pkg::VBKPRCH_VGA;
	localparam int FRAME_VGA = H_VGA * V_VGA;
	localparam int SWITCH_WAIT = 3 + video_mode_pkg::DEBOUNCE_CYCLES + video_mode_pkg::GO_DELAY + 8;
	localparam int WATCHDOG_CYCLES = 3 * FRAME_VGA + 32 * SWITCH_WAIT;

	logic                        clk50m_bufg;
	logic                        RSTBTN;
	logic [3:0]                  sw;
	video_mode_pkg::video_mode_e mode;
	logic [7:0]                  pclk_m;
	logic [7:0]                  pclk_d;
	logic                        prog_go;
	logic [10:0]                 hcount;
	logic [10:0]                 vcount;
	logic                        hsync;
	logic                        vsync;
	logic                        de;
	int                          timeouts = 0;

	video_mode_top dut_i (
		.clk50m_bufg (clk50m_bufg), .RSTBTN (RSTBTN), .sw (sw), .mode (mode),
		.pclk_m (pclk_m), .pclk_d (pclk_d), .prog_go (prog_go), .hcount (hcount),
		.vcount (vcount), .hsync (hsync), .vsync (vsync), .de (de)
	);

	tb_video_checks checks_i (
		.clk50m_bufg (clk50m_bufg), .RSTBTN (RSTBTN), .sw (sw), .mode (mode),
		.mode_change (dut_i.mode_change), .pclk_m (pclk_m), .pclk_d (pclk_d),
		.prog_go (prog_go), .hcount (hcount), .vcount (vcount), .hsync (hsync),
		.vsync (vsync), .de (de)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;  // 50 MHz
	end

	// Clock edges, then a little past the last one
	task automatic step(input int n);
		repeat (n) @(posedge clk50m_bufg);
		#2;
	endtask

	task automatic wait_for_go();
		int n = 0;
		while (prog_go !== 1'b1 && n < SWITCH_WAIT) begin
			step(1);
			n++;
		end
		if (prog_go !== 1'b1) begin
			timeouts++;
			$display("%0t: timed out waiting for prog_go", $time);
		end
	endtask

	// New switch code, then its mode and its clock load
	task automatic select_mode(input logic [3:0] code);
		int n = 0;
		sw = code;
		while (mode !== code && n < SWITCH_WAIT) begin
			step(1);
			n++;
		end
		if (mode !== code) begin
			timeouts++;
			$display("%0t: timed out waiting for mode %b", $time, code);
		end
		wait_for_go();
	endtask

	task automatic wait_for_line(input int line);
		int n = 0;
		while (vcount != line && n < FRAME_VGA) begin
			step(1);
			n++;
		end
		if (vcount != line) begin
			timeouts++;
			$display("%0t: timed out waiting for line %0d", $time, line);
		end
	endtask

	// Short excursions away from the held code and back
	task automatic bounce_switches(input int count);
		logic [3:0] home;
		logic [3:0] other;
		int len;
		home = sw;
		repeat (count) begin
			other = 4'($urandom % 16);
			if (other == home)
				other = other ^ 4'b0001;
			len = 1 + int'($urandom % (video_mode_pkg::DEBOUNCE_CYCLES - 1));
			sw = other;
			step(len);
			sw = home;
			step(1 + int'($urandom % 8));
		end
		step(SWITCH_WAIT);  // Room for a wrong accept and its go strobe
	endtask

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		void'($urandom(32'hd4b8));
		RSTBTN = 1'b1;
		sw     = '0;
		step(5);
		RSTBTN = 1'b0;
		wait_for_go();                           // Power-up load, VGA
		select_mode(video_mode_pkg::MODE_SXGA);
		bounce_switches(12);
		select_mode(4'b0100);                    // Unlisted, runs as 720p
		wait_for_line(3);
		select_mode(video_mode_pkg::MODE_SVGA);
		wait_for_line(3);
		select_mode(video_mode_pkg::MODE_VGA);
		wait_for_line(V_VGA - 1);                // Through vsync to the last line
		wait_for_line(0);
		step(8);
		$display("Errors: %0d check failures, %0d wait timeouts", checks_i.errors, timeouts);
		if (checks_i.errors == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk50m_bufg);
		$display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: files.f
logic/video_mode_pkg.sv
logic/mode_switch_filter.sv
logic/pixel_clock_setup.sv
logic/mode_timing_table.sv
logic/raster_timing.sv
logic/video_mode_top.sv
tests/tb_video_checks.sv
tests/tb_video_mode.sv

// File: Bender.yml
package:
  name: video_mode

sources:
  - logic/video_mode_pkg.sv
  - logic/mode_switch_filter.sv
  - logic/pixel_clock_setup.sv
  - logic/mode_timing_table.sv
  - logic/raster_timing.sv
  - logic/video_mode_top.sv
  - target: simulation
    files:
      - tests/tb_video_checks.sv
      - tests/tb_video_mode.sv
